/* gameBus.f */
hw/systemConsts.sv
hw/busTypes.sv
hw/addressTranslator.sv
hw/cpuDataPath.sv
hw/soundLatchFifo.sv
hw/soundCommandPort.sv
hw/gameBus.sv
testbench/gameBusMapModel.sv
testbench/gameBusTb.sv

/* hw/addressTranslator.sv */
`timescale 1ns/10ps
`default_nettype none

module addressTranslator (
    input  systemConsts::gameT    game,
    input  logic [1:0]            dsN,
    input  logic [23:0]           wordAddr,
    input  logic                  ssRestart,
    output busTypes::chipSelectsT selects
);

    logic knownGame;
    logic isIntVector;

    assign knownGame = game inside {systemConsts::gameFinalb, systemConsts::gameDinorex,
                                    systemConsts::gameQjinsei, systemConsts::gameLiquidk};

    assign isIntVector = (wordAddr == systemConsts::intVectorLo) ||
                         (wordAddr == systemConsts::intVectorHi);

    always_comb begin
        selects = '1;                                       // nothing selected.

        if (!(&dsN) && knownGame) begin
            // ##############################
            // save-state overrides
            // ##############################
            if (wordAddr < systemConsts::vectorSpan) begin
                if (ssRestart) begin
                    selects.ssResetN = 1'b0;
                end else begin
                    selects.romN = 1'b0;
                end
            end else if (isIntVector && game != systemConsts::gameLiquidk) begin
                selects.ssVecN = 1'b0;                      // liquid kids keeps its own vectors.
            end else if (wordAddr[23:8] == systemConsts::saveWindowPage) begin
                selects.ssSaveN = 1'b0;
            end else begin
                // ##############################
                // per game maps
                // ##############################
                case (game)
                    systemConsts::gameFinalb: begin
                        casez (wordAddr)
                            24'h0?????: selects.romN = 1'b0;
                            24'h1?????: selects.workN = 1'b0;
                            24'h2?????: selects.colorN = 1'b0;
                            24'h30????: selects.ioN = 1'b0;
                            24'h32????: selects.soundN = 1'b0;
                            24'h8?????: selects.screenN = 1'b0;
                            24'h9?????: selects.objectN = 1'b0;
                            default: ;
                        endcase
                    end

                    systemConsts::gameDinorex: begin
                        casez (wordAddr)
                            24'h0?????: selects.romN = 1'b0;
                            24'h1?????: selects.romN = 1'b0;
                            24'h2?????: selects.romN = 1'b0;    // third rom bank.
                            24'h30????: selects.ioN = 1'b0;
                            24'h4?????: selects.extensionN = 1'b0;
                            24'h5?????: selects.colorN = 1'b0;
                            24'h6?????: selects.workN = 1'b0;
                            24'h8?????: selects.objectN = 1'b0;
                            24'h9?????: selects.screenN = 1'b0;
                            24'ha0????: selects.soundN = 1'b0;
                            default: ;
                        endcase
                    end

                    systemConsts::gameQjinsei: begin
                        casez (wordAddr)
                            24'h0?????: selects.romN = 1'b0;
                            24'h1?????: selects.romN = 1'b0;
                            24'h20????: selects.soundN = 1'b0;
                            24'h3?????: selects.workN = 1'b0;
                            24'h6?????: selects.extensionN = 1'b0;
                            24'h7?????: selects.colorN = 1'b0;
                            24'h8?????: selects.screenN = 1'b0;
                            24'h9?????: selects.objectN = 1'b0;
                            24'hb0????: selects.ioN = 1'b0;
                            default: ;
                        endcase
                    end

                    systemConsts::gameLiquidk: begin
                        casez (wordAddr)
                            24'h0?????: selects.romN = 1'b0;
                            24'h1?????: selects.workN = 1'b0;
                            24'h2?????: selects.colorN = 1'b0;
                            24'h30????: selects.ioN = 1'b0;
                            24'h32????: selects.soundN = 1'b0;
                            24'h8?????: selects.screenN = 1'b0;
                            24'h9?????: selects.objectN = 1'b0;
                            default: ;
                        endcase
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hw/busTypes.sv */
`default_nettype none

package busTypes;

    // ##############################
    // cpu side
    // ##############################

    // one bus cycle as seen by the board.
    typedef struct packed {
        logic        strobe;     // high for the single cycle of an access.
        logic        write;
        logic [1:0]  dsN;        // upper byte on bit 1, lower byte on bit 0.
        logic [23:0] wordAddr;
        logic [15:0] writeData;
    } cpuReqT;

    // active-low region selects.
    typedef struct packed {
        logic workN;
        logic romN;
        logic screenN;
        logic colorN;
        logic ioN;
        logic objectN;
        logic soundN;
        logic extensionN;
        logic ssSaveN;
        logic ssResetN;
        logic ssVecN;
    } chipSelectsT;

    // ##############################
    // sound side
    // ##############################

    typedef struct packed {
        logic [2:0] fifoCount;
        logic       fifoFull;
        logic       fifoEmpty;
    } soundStatusT;

endpackage

`default_nettype wire

/* hw/cpuDataPath.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuDataPath #(
    parameter int workWords  = 4096,
    parameter int colorWords = 1024
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  busTypes::cpuReqT      req,
    input  busTypes::chipSelectsT selects,
    input  logic [31:0]           playerInputs,
    input  busTypes::soundStatusT soundStatus,
    output logic                  soundPush,
    output logic [7:0]            soundPushData,
    output logic [15:0]           readData,
    output logic                  readValid
);

    localparam int workAw  = $clog2(workWords);
    localparam int colorAw = $clog2(colorWords);

    logic [1:0][7:0] workRam  [workWords];
    logic [1:0][7:0] colorRam [colorWords];

    logic              cpuWrite;
    logic              cpuRead;
    logic [workAw-1:0] workIdx;
    logic [colorAw-1:0] colorIdx;

    assign cpuWrite = req.strobe && req.write;
    assign cpuRead  = req.strobe && !req.write;
    assign workIdx  = req.wordAddr[workAw-1:0];
    assign colorIdx = req.wordAddr[colorAw-1:0];

    // ##############################
    // writes
    // ##############################

    always_ff @(posedge clk) begin
        if (cpuWrite && !selects.workN) begin
            if (!req.dsN[1]) workRam[workIdx][1] <= req.writeData[15:8];
            if (!req.dsN[0]) workRam[workIdx][0] <= req.writeData[7:0];
        end
        if (cpuWrite && !selects.colorN) begin
            if (!req.dsN[1]) colorRam[colorIdx][1] <= req.writeData[15:8];
            if (!req.dsN[0]) colorRam[colorIdx][0] <= req.writeData[7:0];
        end
    end

    assign soundPush     = cpuWrite && !selects.soundN;     // dropped by the fifo when full.
    assign soundPushData = req.writeData[7:0];

    // ##############################
    // reads
    // ##############################

    always_ff @(posedge clk) begin
        if (cpuRead) begin
            if (!selects.workN) begin
                readData <= workRam[workIdx];
            end else if (!selects.colorN) begin
                readData <= colorRam[colorIdx];
            end else if (!selects.ioN) begin
                readData <= req.wordAddr[0] ? playerInputs[31:16] : playerInputs[15:0];
            end else if (!selects.soundN) begin
                readData <= {11'd0, soundStatus};           // status sits in the low bits.
            end else begin
                readData <= 16'd0;                          // regions served elsewhere.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            readValid <= 1'b0;
        end else begin
            readValid <= cpuRead;                           // one cycle after the strobe.
        end
    end

endmodule

`default_nettype wire

/* hw/gameBus.sv */
`timescale 1ns/10ps
`default_nettype none

module gameBus #(
    parameter int workWords  = 4096,
    parameter int colorWords = 1024,
    parameter int fifoDepth  = 4
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  systemConsts::gameT    game,
    input  logic                  ssRestart,
    input  busTypes::cpuReqT      cpuReq,
    input  logic [31:0]           playerInputs,
    input  logic                  soundRead,
    output busTypes::chipSelectsT chipSelects,
    output logic [15:0]           readData,
    output logic                  readValid,
    output logic [7:0]            soundCommand,
    output logic                  soundPending
);

    logic                  soundPush;
    logic [7:0]            soundPushData;
    logic                  soundPop;
    logic [7:0]            soundHead;
    busTypes::soundStatusT soundStatus;

    // ##############################
    // cpu side
    // ##############################

    addressTranslator addressTranslator (
        .game      (game),
        .dsN       (cpuReq.dsN),
        .wordAddr  (cpuReq.wordAddr),
        .ssRestart (ssRestart),
        .selects   (chipSelects)
    );

    cpuDataPath #(
        .workWords  (workWords),
        .colorWords (colorWords)
    ) cpuDataPath (
        .clk           (clk),
        .rstN          (rstN),
        .req           (cpuReq),
        .selects       (chipSelects),
        .playerInputs  (playerInputs),
        .soundStatus   (soundStatus),
        .soundPush     (soundPush),
        .soundPushData (soundPushData),
        .readData      (readData),
        .readValid     (readValid)
    );

    // ##############################
    // sound side
    // ##############################

    soundLatchFifo #(
        .fifoDepth (fifoDepth)
    ) soundLatchFifo (
        .clk      (clk),
        .rstN     (rstN),
        .push     (soundPush),
        .pushData (soundPushData),
        .pop      (soundPop),
        .headData (soundHead),
        .status   (soundStatus)
    );

    soundCommandPort soundCommandPort (
        .clk       (clk),
        .rstN      (rstN),
        .soundRead (soundRead),
        .fifoEmpty (soundStatus.fifoEmpty),
        .headData  (soundHead),
        .pop       (soundPop),
        .command   (soundCommand),
        .pending   (soundPending)
    );

endmodule

`default_nettype wire

/* hw/soundCommandPort.sv */
`timescale 1ns/10ps
`default_nettype none

module soundCommandPort (
    input  logic       clk,
    input  logic       rstN,
    input  logic       soundRead,
    input  logic       fifoEmpty,
    input  logic [7:0] headData,
    output logic       pop,
    output logic [7:0] command,
    output logic       pending
);

    // ##############################
    // command latch
    // ##############################

    // a read with nothing queued leaves the last command in place.
    assign pop = soundRead && !fifoEmpty;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            command <= 8'd0;
        end else if (pop) begin
            command <= headData;                            // fifo advances on the same edge.
        end
    end

    // more commands still wait behind the latched one.
    assign pending = !fifoEmpty;

endmodule

`default_nettype wire

/* hw/soundLatchFifo.sv */
`timescale 1ns/10ps
`default_nettype none

module soundLatchFifo #(
    parameter int fifoDepth = 4
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  push,
    input  logic [7:0]            pushData,
    input  logic                  pop,
    output logic [7:0]            headData,
    output busTypes::soundStatusT status
);

    localparam int ptrW = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
    localparam logic [ptrW-1:0] lastSlot = ptrW'(fifoDepth - 1);

    logic [7:0]      mem [fifoDepth];
    logic [ptrW-1:0] rdPtr;
    logic [ptrW-1:0] wrPtr;
    logic [2:0]      count;
    logic            full;
    logic            empty;
    logic            doPush;
    logic            doPop;

    assign full   = (count == 3'(fifoDepth));
    assign empty  = (count == 3'd0);
    assign doPush = push && !full;                          // a push into a full fifo is lost.
    assign doPop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= 3'd0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == lastSlot) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == lastSlot) ? '0 : rdPtr + 1'b1;
            end
            count <= count + 3'(doPush) - 3'(doPop);        // both at once leaves it unchanged.
        end
    end

    assign headData         = mem[rdPtr];
    assign status.fifoCount = count;
    assign status.fifoFull  = full;
    assign status.fifoEmpty = empty;

endmodule

`default_nettype wire

/* hw/systemConsts.sv */
`default_nettype none

package systemConsts;

    // ##############################
    // boards
    // ##############################

    // board selected by the top level. gameNone parks the decoder.
    typedef enum logic [2:0] {
        gameNone    = 3'd0,
        gameFinalb  = 3'd1,
        gameDinorex = 3'd2,
        gameQjinsei = 3'd3,
        gameLiquidk = 3'd4
    } gameT;

    // ##############################
    // fixed map locations
    // ##############################

    // word addresses below this hold the reset vectors.
    localparam logic [23:0] vectorSpan = 24'd16;

    // the two interrupt vector words taken over by the save-state engine.
    localparam logic [23:0] intVectorLo = 24'h00007c;
    localparam logic [23:0] intVectorHi = 24'h00007e;

    // upper 16 address bits of the save-state window.
    localparam logic [15:0] saveWindowPage = 16'hff00;

    // width of the command byte handed to the sound side.
    localparam int soundByteBits = 8;

endpackage

`default_nettype wire

/* testbench/gameBusMapModel.sv */
`timescale 1ns/10ps
`default_nettype none

module gameBusMapModel #(
    parameter int workWords  = 4096,
    parameter int colorWords = 1024
);

    logic [15:0] workShadow  [workWords];
    logic [15:0] colorShadow [colorWords];

    // ##############################
    // reference memory map
    // ##############################

    function automatic busTypes::chipSelectsT expectedSelects(input systemConsts::gameT g,
            input logic [1:0] dsN, input logic [23:0] a, input logic restart);
        busTypes::chipSelectsT s;
        logic [3:0] nib;
        logic [7:0] top;
        s = '1;
        nib = a[23:20];
        top = a[23:16];
        if (dsN == 2'b11 || !(g inside {systemConsts::gameFinalb, systemConsts::gameDinorex,
                systemConsts::gameQjinsei, systemConsts::gameLiquidk})) return s;
        if (a <= 24'h00000f) begin
            if (restart) s.ssResetN = 1'b0;
            else s.romN = 1'b0;
        end else if ((a == 24'h00007c || a == 24'h00007e) && g != systemConsts::gameLiquidk) begin
            s.ssVecN = 1'b0;
        end else if (a[23:8] == 16'hff00) begin
            s.ssSaveN = 1'b0;                                   // save window page.
        end else if (g == systemConsts::gameDinorex) begin
            if (nib <= 4'h2) s.romN = 1'b0;
            else if (top == 8'h30) s.ioN = 1'b0;
            else if (nib == 4'h4) s.extensionN = 1'b0;
            else if (nib == 4'h5) s.colorN = 1'b0;
            else if (nib == 4'h6) s.workN = 1'b0;
            else if (nib == 4'h8) s.objectN = 1'b0;
            else if (nib == 4'h9) s.screenN = 1'b0;
            else if (top == 8'ha0) s.soundN = 1'b0;
        end else if (g == systemConsts::gameQjinsei) begin
            if (nib <= 4'h1) s.romN = 1'b0;
            else if (top == 8'h20) s.soundN = 1'b0;
            else if (nib == 4'h3) s.workN = 1'b0;
            else if (nib == 4'h6) s.extensionN = 1'b0;
            else if (nib == 4'h7) s.colorN = 1'b0;
            else if (nib == 4'h8) s.screenN = 1'b0;
            else if (nib == 4'h9) s.objectN = 1'b0;
            else if (top == 8'hb0) s.ioN = 1'b0;
        end else begin
            if (nib == 4'h0) s.romN = 1'b0;                     // final blow and liquid kids.
            else if (nib == 4'h1) s.workN = 1'b0;
            else if (nib == 4'h2) s.colorN = 1'b0;
            else if (top == 8'h30) s.ioN = 1'b0;
            else if (top == 8'h32) s.soundN = 1'b0;
            else if (nib == 4'h8) s.screenN = 1'b0;
            else if (nib == 4'h9) s.objectN = 1'b0;
        end
        return s;
    endfunction

    // byte-enabled update of the shadow word.
    task automatic storeWord(input logic isColor, input int idx, input logic [1:0] dsN,
            input logic [15:0] data);
        logic [15:0] w;
        w = isColor ? colorShadow[idx] : workShadow[idx];
        if (!dsN[1]) w[15:8] = data[15:8];
        if (!dsN[0]) w[7:0] = data[7:0];
        if (isColor) colorShadow[idx] = w;
        else workShadow[idx] = w;
    endtask

endmodule

`default_nettype wire

/* testbench/gameBusTb.sv */
`timescale 1ns/10ps
`default_nettype none

module gameBusTb;

    localparam int workWords    = 4096;
    localparam int colorWords   = 1024;
    localparam int fifoDepth    = 4;
    localparam int workAw       = $clog2(workWords);
    localparam int colorAw      = $clog2(colorWords);
    localparam int decodeRandom = 16;
    localparam int edgeCount    = 24;
    localparam int testCycles   = 10 + 10 * (decodeRandom + edgeCount) + 80 + 16 * 5 + 8 * 5 + 6
                                  + 3 * fifoDepth + 8 + 20;
    localparam int cycleLimit   = 2 * testCycles + 200;

    logic clk;
    logic rstN;
    systemConsts::gameT game;
    logic ssRestart;
    busTypes::cpuReqT cpuReq;
    logic [31:0] playerInputs;
    logic soundRead;
    busTypes::chipSelectsT chipSelects;
    logic [15:0] readData;
    logic readValid;
    logic [7:0] soundCommand;
    logic soundPending;

    logic [15:0] lfsrState;
    int cycleCount = 0;
    int testErrors;
    int errorCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    string testName;
    logic [23:0] edgeAddrs [edgeCount];
    logic [7:0] keptCommands [$];

    gameBus #(.workWords(workWords), .colorWords(colorWords), .fifoDepth(fifoDepth)) UUT (
        .clk(clk), .rstN(rstN), .game(game), .ssRestart(ssRestart), .cpuReq(cpuReq),
        .playerInputs(playerInputs), .soundRead(soundRead), .chipSelects(chipSelects),
        .readData(readData), .readValid(readValid), .soundCommand(soundCommand),
        .soundPending(soundPending)
    );

    gameBusMapModel #(.workWords(workWords), .colorWords(colorWords)) mapModel ();

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ##############################
    // helpers
    // ##############################

    // galois lfsr stepped once per bit taken.
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic outBit;
        v = '0;
        for (int i = 0; i < n; i++) begin
            outBit = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (outBit) lfsrState = lfsrState ^ 16'hb400;
            v = {v[30:0], outBit};
        end
        return v;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic setIdle();
        cpuReq = '0;
        cpuReq.dsN = 2'b11;
    endtask

    task automatic checkValue(input string what, input logic [31:0] expected,
            input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s %s expected %h actual %h", testName, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrors = 0;
    endtask

    task automatic finishTest();
        testsRun++;
        if (testErrors == 0) begin
            $display("PASS %s", testName);
        end else begin
            $display("FAIL %s with %0d mismatches", testName, testErrors);
            testsFailed++;
            errorCount += testErrors;
        end
    endtask

    task automatic busWrite(input logic [23:0] addr, input logic [1:0] ds, input logic [15:0] data);
        cpuReq = '{strobe: 1'b1, write: 1'b1, dsN: ds, wordAddr: addr, writeData: data};
        nextCycle();
        setIdle();
    endtask

    // readValid must rise exactly one cycle after the strobe.
    task automatic busRead(input logic [23:0] addr, input logic [15:0] expected, input string what);
        cpuReq = '{strobe: 1'b1, write: 1'b0, dsN: 2'b00, wordAddr: addr, writeData: 16'd0};
        #3 checkValue("readValid early", 32'd0, 32'(readValid));
        nextCycle();
        setIdle();
        #3 checkValue("readValid", 32'd1, 32'(readValid));
        checkValue(what, 32'(expected), 32'(readData));
        nextCycle();
        #3 checkValue("readValid late", 32'd0, 32'(readValid));
        nextCycle();
    endtask

    task automatic decodeCheck(input logic [23:0] addr, input logic [1:0] ds);
        cpuReq.dsN = ds;
        cpuReq.wordAddr = addr;
        #3 checkValue($sformatf("selects at %h", addr),
                      32'(mapModel.expectedSelects(game, ds, addr, ssRestart)), 32'(chipSelects));
        nextCycle();
    endtask

    task automatic ramTest(input logic isColor, input int count);
        int idxList [16];
        logic [23:0] base;
        logic [15:0] data;
        logic [1:0] ds;
        base = isColor ? 24'h200000 : 24'h100000;
        for (int i = 0; i < count; i++) begin
            idxList[i] = int'(randBits(isColor ? colorAw : workAw));
            data = 16'(randBits(16));
            busWrite(base | 24'(idxList[i]), 2'b00, data);
            mapModel.storeWord(isColor, idxList[i], 2'b00, data);
        end
        for (int i = 0; i < count; i++) begin
            ds = 2'(randBits(2));
            data = 16'(randBits(16));
            busWrite(base | 24'(idxList[i]), ds, data);
            mapModel.storeWord(isColor, idxList[i], ds, data);
        end
        for (int i = 0; i < count; i++) begin
            busRead(base | 24'(idxList[i]), isColor ? mapModel.colorShadow[idxList[i]]
                                                    : mapModel.workShadow[idxList[i]], "ram word");
        end
    endtask

    // ##############################
    // tests
    // ##############################

    initial begin
        logic [1:0] ds;
        logic [7:0] data;
        lfsrState = 16'd5966;
        rstN = 1'b0;
        game = systemConsts::gameNone;
        ssRestart = 1'b0;
        setIdle();
        playerInputs = 32'd0;
        soundRead = 1'b0;
        edgeAddrs = '{24'h000000, 24'h00000f, 24'h000010, 24'h00007c, 24'h00007e, 24'h00007f,
                      24'h0fffff, 24'h100000, 24'h200000, 24'h2fffff, 24'h300000, 24'h30ffff,
                      24'h310000, 24'h320000, 24'h400000, 24'h5fffff, 24'h600000, 24'h7fffff,
                      24'h800000, 24'h9fffff, 24'ha00000, 24'hb00000, 24'hff0010, 24'hff0100};
        repeat (10) nextCycle();
        rstN = 1'b1;

        startTest("decode");
        for (int g = 0; g < 5; g++) begin
            game = systemConsts::gameT'(g);
            for (int r = 0; r < 2; r++) begin
                ssRestart = r[0];
                for (int i = 0; i < decodeRandom; i++) begin
                    ds = 2'(randBits(2));
                    decodeCheck(24'(randBits(24)), (ds == 2'b11) ? 2'b00 : ds);
                end
                for (int i = 0; i < edgeCount; i++) decodeCheck(edgeAddrs[i], 2'(i % 3));
            end
        end
        finishTest();

        startTest("no byte strobe");
        for (int g = 0; g < 5; g++) begin
            game = systemConsts::gameT'(g);
            ssRestart = g[0];
            for (int i = 0; i < 16; i++) begin
                cpuReq.dsN = 2'b11;
                cpuReq.wordAddr = (i == 0) ? 24'd0 : 24'(randBits(24));
                #3 checkValue("selects", 32'h7ff, 32'(chipSelects));      // all eleven high.
                nextCycle();
            end
        end
        finishTest();

        game = systemConsts::gameFinalb;
        ssRestart = 1'b0;
        startTest("work ram");
        ramTest(1'b0, 16);
        finishTest();

        startTest("color ram and inputs");
        ramTest(1'b1, 8);
        playerInputs = randBits(32);
        busRead(24'h300000, playerInputs[15:0], "input low");
        busRead(24'h300001, playerInputs[31:16], "input high");
        finishTest();

        startTest("sound fifo");
        for (int i = 0; i < fifoDepth + 2; i++) begin
            data = 8'(randBits(8));
            if (i < fifoDepth) keptCommands.push_back(data);    // the last two are dropped.
            busWrite(24'h320000, 2'b00, {8'h00, data});
        end
        busRead(24'h320000, {11'd0, 3'(fifoDepth), 1'b1, 1'b0}, "full status");
        for (int i = 0; i < fifoDepth; i++) begin
            soundRead = 1'b1;
            nextCycle();
            soundRead = 1'b0;
            #3 checkValue("command", 32'(keptCommands[i]), 32'(soundCommand));
            checkValue("pending", 32'(i < fifoDepth - 1), 32'(soundPending));
            nextCycle();
        end
        soundRead = 1'b1;                                       // nothing left to pop.
        nextCycle();
        soundRead = 1'b0;
        #3 checkValue("command held", 32'(keptCommands[fifoDepth - 1]), 32'(soundCommand));
        nextCycle();
        finishTest();

        startTest("reset");
        busWrite(24'h320000, 2'b00, 16'h005a);
        cpuReq = '{strobe: 1'b1, write: 1'b0, dsN: 2'b00, wordAddr: 24'h100000, writeData: 16'd0};
        rstN = 1'b0;
        nextCycle();
        setIdle();
        #3 checkValue("readValid", 32'd0, 32'(readValid));     // the read strobe met reset.
        repeat (9) nextCycle();
        rstN = 1'b1;
        #3 checkValue("pending", 32'd0, 32'(soundPending));
        checkValue("command", 32'd0, 32'(soundCommand));
        nextCycle();
        busRead(24'h320000, 16'h0001, "empty status");
        finishTest();

        $display("tests %0d, failed %0d, mismatches %0d", testsRun, testsFailed, errorCount);
        if (testsFailed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
